//--- logic/sram_alloc_pkg.sv
package sram_alloc_pkg;

    // Buffer SRAM count and the width of an index into them
    localparam int NUM_SRAM   = 32;
    localparam int SRAM_IDX_W = 5;

    // Destination ports of the switch
    localparam int NUM_PORT = 16;
    localparam int PORT_W   = 4;

    // Packet length in bytes as presented by the front end
    localparam int LEN_W = 9;

    // Free space is counted in 8-byte units
    localparam int SPACE_W    = 11;
    localparam int UNIT_SHIFT = 3;

    // Width of a per-SRAM, per-port packet counter
    localparam int AMOUNT_W = 9;

    // Width of the scan-window threshold and of the matcher tick
    localparam int TICK_W = 5;

    // Free space of every SRAM after reset, in units
    // Small on purpose so that a modest packet stream fills SRAMs
    localparam int SRAM_CAPACITY = 64;

    // Space a packet needs, in 8-byte units
    // The remainder is dropped, so only the upper bits of the length count
    function automatic logic [SPACE_W-1:0] len_units(input logic [LEN_W-1:0] len);
        logic [LEN_W-1:0] shifted;
        shifted = len >> UNIT_SHIFT;
        return SPACE_W'(shifted);
    endfunction

endpackage

//--- logic/sram_status_table.sv
`timescale 1ns/1ps

module sram_status_table import sram_alloc_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    // Combinational read port, addressed by the scan cursor
    input  logic [SRAM_IDX_W-1:0] rd_sram,
    input  logic [PORT_W-1:0]     rd_port,
    input  logic [NUM_SRAM-1:0]   sram_enable,
    output logic                  accessible,
    output logic [SPACE_W-1:0]    free_space,
    output logic [AMOUNT_W-1:0]   packet_amount,

    // Update port, driven by the commit stage
    input  logic                  upd_valid,
    input  logic [SRAM_IDX_W-1:0] upd_sram,
    input  logic [SPACE_W-1:0]    upd_units,
    input  logic [PORT_W-1:0]     upd_port
);

    // Remaining space of each SRAM in 8-byte units
    logic [SPACE_W-1:0]  free_q [NUM_SRAM];

    // Number of stored packets per SRAM and destination port
    logic [AMOUNT_W-1:0] count_q [NUM_SRAM][NUM_PORT];

    // The enable bit comes straight from the outside, so an SRAM can be
    // switched off between two requests without touching the table
    assign accessible    = sram_enable[rd_sram];
    assign free_space    = free_q[rd_sram];
    assign packet_amount = count_q[rd_sram][rd_port];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Every SRAM starts empty with its full capacity free
            for (int s = 0; s < NUM_SRAM; s++) begin
                free_q[s] <= SPACE_W'(SRAM_CAPACITY);
                for (int p = 0; p < NUM_PORT; p++) begin
                    count_q[s][p] <= '0;
                end
            end
        end else if (upd_valid) begin
            // One packet admitted: take its space and count it for its port
            free_q[upd_sram]            <= free_q[upd_sram] - upd_units;
            count_q[upd_sram][upd_port] <= count_q[upd_sram][upd_port] + 1'b1;
        end
    end

    // The matcher only picks SRAMs with enough room, so a committed update
    // must always fit into the space the table still holds
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        upd_valid |-> (free_q[upd_sram] >= upd_units)
    ) else $error("free space underflow on SRAM %0d", upd_sram);

endmodule

//--- logic/sram_scan_cursor.sv
`timescale 1ns/1ps

module sram_scan_cursor import sram_alloc_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  logic                  ack,
    input  logic                  match_suc,
    output logic                  match_enable,
    output logic [SRAM_IDX_W-1:0] matching_sram
);

    // A request is pending while req is up and not yet answered
    // The enable drops right after the matcher reports success, so it is
    // already low when ack rises on the following edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_enable <= 1'b0;
        end else begin
            match_enable <= req && !ack && !match_suc;
        end
    end

    // Index of the SRAM under scan
    // It restarts at 0 for every request and walks all SRAMs in turn
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            matching_sram <= '0;
        end else if (!match_enable) begin
            matching_sram <= '0;
        end else if (matching_sram == SRAM_IDX_W'(NUM_SRAM - 1)) begin
            matching_sram <= '0;
        end else begin
            matching_sram <= matching_sram + 1'b1;
        end
    end

    // A new scan must not start while the previous answer is still on ack
    a_no_enable_under_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(match_enable) |-> !ack
    ) else $error("match_enable rose while ack is high");

endmodule

//--- logic/port_wr_sram_matcher.sv
`timescale 1ns/1ps

module port_wr_sram_matcher import sram_alloc_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [TICK_W-1:0]     match_threshold,

    // Request side
    input  logic [LEN_W-1:0]      new_length,
    input  logic                  match_enable,
    output logic                  match_suc,

    // Scan side: the SRAM under test and the best one so far
    input  logic [SRAM_IDX_W-1:0] matching_sram,
    output logic [SRAM_IDX_W-1:0] matching_best_sram,
    output logic                  update_matched_sram,

    // Status of the SRAM under test, read from the table
    input  logic                  accessible,
    input  logic [SPACE_W-1:0]    free_space,
    input  logic [AMOUNT_W-1:0]   packet_amount
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MATCH,
        ST_DONE
    } match_state_t;

    match_state_t        state_q;
    logic                matching_find;
    logic [TICK_W-1:0]   matching_tick;
    logic [AMOUNT_W-1:0] max_amount;
    logic                scanning;
    logic                window_end;

    // Candidates are only looked at while a request waits and no result
    // has been handed out for it yet
    assign scanning   = match_enable && (state_q != ST_DONE);
    assign window_end = scanning && (matching_tick == match_threshold);

    // The SRAM under test replaces the best one when it is enabled, has
    // room for the packet and holds at least as many packets for the port
    // Using >= hands ties to the SRAM scanned later
    assign update_matched_sram = scanning && accessible
                                 && (free_space >= len_units(new_length))
                                 && (packet_amount >= max_amount);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            match_suc <= 1'b0;
        end else begin
            match_suc <= 1'b0;
            case (state_q)
                ST_IDLE, ST_MATCH: begin
                    // The SRAM seen in the last tick of the window counts too
                    if (window_end && (matching_find || update_matched_sram)) begin
                        state_q   <= ST_DONE;
                        match_suc <= 1'b1;
                    end else if (match_enable) begin
                        state_q <= ST_MATCH;
                    end else begin
                        state_q <= ST_IDLE;
                    end
                end
                // match_suc is high for exactly this one state
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Scan tick, restarted at the end of each window
    // An empty window simply runs again from tick 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            matching_tick <= '0;
        end else if (!scanning || (matching_tick == match_threshold)) begin
            matching_tick <= '0;
        end else begin
            matching_tick <= matching_tick + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            matching_find <= 1'b0;
            max_amount    <= '0;
        end else if (!scanning) begin
            matching_find <= 1'b0;
            max_amount    <= '0;
        end else if (update_matched_sram) begin
            matching_find <= 1'b1;
            max_amount    <= packet_amount;
        end
    end

    always_ff @(posedge clk) begin
        if (update_matched_sram) begin
            matching_best_sram <= matching_sram;
        end
    end

    // A success retires the request in the cursor, so the pulse cannot
    // repeat and no new window opens for the same request
    a_suc_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        match_suc |=> (!match_suc && !match_enable)
    ) else $error("match_suc not followed by the end of the request");

    // The cursor keeps the request pending until it sees the success pulse
    a_suc_needs_enable: assert property (
        @(posedge clk) disable iff (!rst_n)
        match_suc |-> match_enable
    ) else $error("match_suc without a pending request");

endmodule

//--- logic/sram_alloc_commit.sv
`timescale 1ns/1ps

module sram_alloc_commit import sram_alloc_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  logic                  match_suc,
    input  logic [SRAM_IDX_W-1:0] matching_best_sram,
    input  logic [LEN_W-1:0]      length,
    input  logic [PORT_W-1:0]     dst_port,
    output logic                  ack,
    output logic [SRAM_IDX_W-1:0] sram_id,
    output logic                  upd_valid,
    output logic [SRAM_IDX_W-1:0] upd_sram,
    output logic [SPACE_W-1:0]    upd_units,
    output logic [PORT_W-1:0]     upd_port
);

    // The table update is issued during the success cycle, so the table
    // write lands on the same edge on which ack rises
    // length and dst_port are still held by the front end at this point
    assign upd_valid = match_suc;
    assign upd_sram  = matching_best_sram;
    assign upd_units = len_units(length);
    assign upd_port  = dst_port;

    // Second half of the four-phase handshake
    // ack stays up until the front end drops req
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else if (match_suc) begin
            ack <= 1'b1;
        end else if (!req) begin
            ack <= 1'b0;
        end
    end

    // The answer is only sampled on a success, so it holds through ack
    always_ff @(posedge clk) begin
        if (match_suc) begin
            sram_id <= matching_best_sram;
        end
    end

    a_id_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ack && $past(ack)) |-> (sram_id == $past(sram_id))
    ) else $error("sram_id changed while ack is high");

endmodule

//--- logic/port_wr_sram_alloc.sv
`timescale 1ns/1ps

module port_wr_sram_alloc import sram_alloc_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    // Front end request, four-phase req/ack
    input  logic                  req,
    input  logic [LEN_W-1:0]      length,
    input  logic [PORT_W-1:0]     dst_port,
    output logic                  ack,
    output logic [SRAM_IDX_W-1:0] sram_id,

    // Configuration
    input  logic [NUM_SRAM-1:0]   sram_enable,
    input  logic [TICK_W-1:0]     match_threshold
);

    logic                  match_enable;
    logic                  match_suc;
    logic [SRAM_IDX_W-1:0] matching_sram;
    logic [SRAM_IDX_W-1:0] matching_best_sram;

    // Status of the SRAM under scan
    logic                  accessible;
    logic [SPACE_W-1:0]    free_space;
    logic [AMOUNT_W-1:0]   packet_amount;

    // Table update from the commit stage
    logic                  upd_valid;
    logic [SRAM_IDX_W-1:0] upd_sram;
    logic [SPACE_W-1:0]    upd_units;
    logic [PORT_W-1:0]     upd_port;

    sram_scan_cursor u_cursor (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .ack           (ack),
        .match_suc     (match_suc),
        .match_enable  (match_enable),
        .matching_sram (matching_sram)
    );

    // The replace strobe is only needed inside the matcher
    port_wr_sram_matcher u_matcher (
        .clk                 (clk),
        .rst_n               (rst_n),
        .match_threshold     (match_threshold),
        .new_length          (length),
        .match_enable        (match_enable),
        .match_suc           (match_suc),
        .matching_sram       (matching_sram),
        .matching_best_sram  (matching_best_sram),
        .update_matched_sram (),
        .accessible          (accessible),
        .free_space          (free_space),
        .packet_amount       (packet_amount)
    );

    sram_alloc_commit u_commit (
        .clk                (clk),
        .rst_n              (rst_n),
        .req                (req),
        .match_suc          (match_suc),
        .matching_best_sram (matching_best_sram),
        .length             (length),
        .dst_port           (dst_port),
        .ack                (ack),
        .sram_id            (sram_id),
        .upd_valid          (upd_valid),
        .upd_sram           (upd_sram),
        .upd_units          (upd_units),
        .upd_port           (upd_port)
    );

    sram_status_table u_table (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_sram       (matching_sram),
        .rd_port       (dst_port),
        .sram_enable   (sram_enable),
        .accessible    (accessible),
        .free_space    (free_space),
        .packet_amount (packet_amount),
        .upd_valid     (upd_valid),
        .upd_sram      (upd_sram),
        .upd_units     (upd_units),
        .upd_port      (upd_port)
    );

endmodule

//--- dv/port_wr_sram_alloc_tb.sv
`timescale 1ns/1ps

module port_wr_sram_alloc_tb import sram_alloc_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int NUM_REQ    = 76;
    // A full window plus the handshake fits well inside NUM_SRAM+8 cycles
    localparam int REQ_CYCLES      = NUM_SRAM + 8;
    localparam int WATCHDOG_CYCLES = NUM_REQ * REQ_CYCLES + 200;

    logic                  clk;
    logic                  rst_n;
    logic                  req;
    logic [LEN_W-1:0]      length;
    logic [PORT_W-1:0]     dst_port;
    logic [NUM_SRAM-1:0]   sram_enable;
    logic [TICK_W-1:0]     match_threshold;
    logic                  ack;
    logic [SRAM_IDX_W-1:0] sram_id;

    // Testbench copy of the status table
    int model_free [NUM_SRAM];
    int model_cnt [NUM_SRAM][NUM_PORT];

    // Expectation for the request in flight
    int exp_id;
    int exp_units;
    int exp_port;

    int error_count;
    int req_count;
    int test_count;

    // Handshake signals as seen one cycle earlier
    logic                  prev_ack;
    logic                  prev_req;

    port_wr_sram_alloc u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .req             (req),
        .length          (length),
        .dst_port        (dst_port),
        .ack             (ack),
        .sram_id         (sram_id),
        .sram_enable     (sram_enable),
        .match_threshold (match_threshold)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Highest count for the port among enabled SRAMs with room
    // Walking down from the top index and replacing only on a strictly
    // larger count leaves ties with the highest index
    function automatic int pick_sram(input int units, input int port,
                                     input logic [NUM_SRAM-1:0] mask);
        int best;
        best = -1;
        for (int s = NUM_SRAM - 1; s >= 0; s--) begin
            if (mask[s] && model_free[s] >= units) begin
                if (best < 0 || model_cnt[s][port] > model_cnt[best][port]) begin
                    best = s;
                end
            end
        end
        return best;
    endfunction

    // One full four-phase handshake, started and ended on a falling edge
    task automatic run_request(input int len, input int port);
        int cycles;
        int hold;
        cycles    = 0;
        hold      = 1 + ($urandom % 3);
        exp_units = len / 8;
        exp_port  = port;
        exp_id    = pick_sram(exp_units, port, sram_enable);
        @(negedge clk);
        length   = LEN_W'(len);
        dst_port = PORT_W'(port);
        req      = 1'b1;
        while (!ack && cycles < REQ_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        assert (ack) else begin
            $display("Request %0d got no ack within %0d cycles", req_count, cycles);
            error_count++;
        end
        // The window alone takes threshold+1 cycles before commit and ack
        assert (cycles >= int'(match_threshold) + 3) else begin
            $display("Request %0d was answered after only %0d cycles", req_count, cycles);
            error_count++;
        end
        // req stays up a little, so ack and sram_id have to hold meanwhile
        repeat (hold) @(negedge clk);
        req    = 1'b0;
        cycles = 0;
        while (ack && cycles < 4) begin
            @(negedge clk);
            cycles++;
        end
        assert (!ack) else begin
            $display("Request %0d kept ack high after req fell", req_count);
            error_count++;
        end
        req_count++;
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        test_count++;
        $display("Test %0d %s finished with %0d errors", test_count, name,
                 error_count - errs_at_start);
    endtask

    // Compare and handshake monitor
    // Sampling on the rising edge sees the values of the cycle just ended
    always @(posedge clk) begin
        if (!rst_n) begin
            prev_ack = 1'b0;
            prev_req = 1'b0;
        end else begin
            if (ack && !prev_ack) begin
                assert (exp_id >= 0 && sram_id == SRAM_IDX_W'(exp_id)) else begin
                    $display("[ERROR] sram_id expected 0x%0h got 0x%0h", exp_id, sram_id);
                    error_count++;
                end
                assert (sram_enable[sram_id]) else begin
                    $display("SRAM %0d was chosen although it is disabled", sram_id);
                    error_count++;
                end
                assert (prev_req) else begin
                    $display("ack rose without a request");
                    error_count++;
                end
                // Account the packet where the model placed it
                if (exp_id >= 0) begin
                    model_free[exp_id] -= exp_units;
                    model_cnt[exp_id][exp_port] += 1;
                end
            end
            // The answer must stay on sram_id for as long as ack is up
            if (ack && prev_ack) begin
                assert (sram_id == SRAM_IDX_W'(exp_id)) else begin
                    $display("[ERROR] sram_id expected 0x%0h got 0x%0h", exp_id, sram_id);
                    error_count++;
                end
            end
            if (!ack && prev_ack) begin
                assert (!prev_req) else begin
                    $display("ack fell while req was still high");
                    error_count++;
                end
            end
            prev_ack = ack;
            prev_req = req;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int                  len;
        int                  port;
        int                  errs;
        logic [NUM_SRAM-1:0] mask;
        void'($urandom(9));
        rst_n           = 1'b0;
        req             = 1'b0;
        length          = '0;
        dst_port        = '0;
        sram_enable     = '1;
        match_threshold = TICK_W'(NUM_SRAM - 1);
        error_count     = 0;
        req_count       = 0;
        test_count      = 0;
        exp_id          = -1;
        exp_units       = 0;
        exp_port        = 0;
        for (int s = 0; s < NUM_SRAM; s++) begin
            model_free[s] = SRAM_CAPACITY;
            for (int p = 0; p < NUM_PORT; p++) begin
                model_cnt[s][p] = 0;
            end
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // Idle bus after reset, then the first pick on an empty table
        errs = error_count;
        repeat (5) begin
            @(negedge clk);
            assert (!ack) else begin
                $display("[ERROR] ack expected 0x0 got 0x%0h", ack);
                error_count++;
            end
        end
        run_request(64, 3);
        report_test("empty_table", errs);

        // Port 3 stays on its SRAM until the 8-unit packets no longer fit
        errs = error_count;
        repeat (9) run_request(64, 3);
        report_test("same_port_affinity", errs);

        // SRAM 30 holds a port 3 packet and has room, but is switched off
        errs = error_count;
        sram_enable     = '1;
        sram_enable[30] = 1'b0;
        run_request(64, 3);
        sram_enable[29] = 1'b0;
        run_request(64, 3);
        sram_enable = '1;
        report_test("disabled_srams", errs);

        // 63-unit packets leave one unit behind, so each lands on a new SRAM
        errs = error_count;
        repeat (4) run_request(511, 5);
        report_test("large_packets", errs);

        // Random traffic with about one SRAM in eight disabled per request
        errs = error_count;
        repeat (60) begin
            mask = ~($urandom & $urandom & $urandom);
            if (mask == '0) begin
                mask = '1;
            end
            len  = $urandom % 512;
            port = $urandom % NUM_PORT;
            // A packet under 8 bytes needs no units and always fits
            if (pick_sram(len / 8, port, mask) < 0) begin
                len = len % 8;
            end
            sram_enable = mask;
            run_request(len, port);
        end
        sram_enable = '1;
        report_test("random_traffic", errs);

        $display("Summary %0d tests, %0d requests, %0d errors", test_count, req_count,
                 error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- port_wr_sram_alloc.f
logic/sram_alloc_pkg.sv
logic/sram_status_table.sv
logic/sram_scan_cursor.sv
logic/port_wr_sram_matcher.sv
logic/sram_alloc_commit.sv
logic/port_wr_sram_alloc.sv
dv/port_wr_sram_alloc_tb.sv

//--- Makefile
TOP := port_wr_sram_alloc_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -Mdir obj_dir -f port_wr_sram_alloc.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
